/* build.f */
hdl/aer_pkg.sv
hdl/rr_group_arbiter.sv
hdl/pixel_arbiter.sv
hdl/aer_event_encoder.sv
hdl/pixel_array_top.sv
test/pixel_arbiter_assertions.sv
test/tb_pixel_array.sv

/* hdl/aer_event_encoder.sv */
// Free-running timestamp and address-event register for new pixel grants
`timescale 1ns/1ps

module aer_event_encoder import aer_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset_i,
    input  pixel_mat_t  gnt_i,                  // Grant matrix from the arbiter
    input  pixel_addr_t addr_i,                 // Address of that grant
    output aer_event_t  event_o,                // Registered event
    output logic        event_valid_o           // One-cycle strobe per event
);

    logic [TS_W-1:0] ts_q;                      // Cycles since reset
    pixel_addr_t     prev_addr_q;               // Grant address of last cycle
    logic            prev_any_q;                // Last cycle had a grant
    aer_event_t      event_q;
    logic            valid_q;

    logic            any_gnt;                   // A pixel holds the grant now
    logic            new_gnt;                   // Grant is new this cycle

    // ------------------------------
    // Timestamp
    // ------------------------------
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            ts_q <= '0;
        else
            ts_q <= ts_q + 1'b1;                // Free running, wraps
    end

    // ------------------------------
    // New grant detection
    // ------------------------------
    assign any_gnt = |gnt_i;
    assign new_gnt = any_gnt & (~prev_any_q | (addr_i != prev_addr_q));

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            prev_addr_q <= '0;
            prev_any_q  <= 1'b0;
        end
        else
        begin
            prev_addr_q <= addr_i;
            prev_any_q  <= any_gnt;
        end
    end

    // ------------------------------
    // Event output
    // ------------------------------
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            valid_q <= 1'b0;
        else
            valid_q <= new_gnt;                 // Strobe follows the grant by one cycle
    end

    always_ff @(posedge clk_i)
    begin
        if (new_gnt)
        begin
            event_q.addr <= addr_i;
            event_q.ts   <= ts_q;               // Time of the grant cycle
        end
    end

    assign event_o       = event_q;
    assign event_valid_o = valid_q;

endmodule

/* hdl/aer_pkg.sv */
// Array sizes, address widths, arbiter FSM states and event types
package aer_pkg;

    // ------------------------------
    // Array geometry
    // ------------------------------
    localparam int ROWS  = 4;                   // Pixel rows
    localparam int COLS  = 4;                   // Pixel columns
    localparam int ROW_W = 2;                   // Row address bits
    localparam int COL_W = 2;                   // Column address bits

    // ------------------------------
    // Event format
    // ------------------------------
    localparam int TS_W  = 16;                  // Timestamp bits, wraps silently

    // One bit per pixel, outer index is the row
    typedef logic [ROWS-1:0][COLS-1:0] pixel_mat_t;

    // Two-level arbitration FSM
    typedef enum logic [1:0]
    {
        ARB_IDLE      = 2'b00,                  // Disabled, arbiters cleared
        ARB_ROW_GRANT = 2'b01,                  // Row arbiter picking a row
        ARB_COL_GRANT = 2'b10                   // Column arbiter sweeping the row
    } arb_state_t;

    // Pixel address as seen on the AER bus
    typedef struct packed
    {
        logic [ROW_W-1:0] x;                    // Row index
        logic [COL_W-1:0] y;                    // Column index
    } pixel_addr_t;

    // Address event, address in the upper bits
    typedef struct packed
    {
        pixel_addr_t      addr;                 // Granted pixel
        logic [TS_W-1:0]  ts;                   // Cycle count at grant
    } aer_event_t;

endpackage

/* hdl/pixel_arbiter.sv */
// Two-level row/column pixel arbitration with control FSM and grant matrix
`timescale 1ns/1ps

module pixel_arbiter import aer_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        enable_i,               // Low aborts and clears fairness state
    input  pixel_mat_t  req_i,                  // Request levels per pixel
    output pixel_mat_t  gnt_o,                  // One-hot or zero
    output pixel_addr_t addr_o,                 // Row and column of the grant
    output logic        active_o,               // A column grant was seen last cycle
    output logic        grp_release_o           // Full sweep finished
);

    arb_state_t state_q, state_d;               // FSM state

    logic [ROWS-1:0]  row_req;                  // Per-row OR of pixel requests
    logic [COLS-1:0]  col_req;                  // Requests of the granted row
    logic [ROWS-1:0]  row_gnt;
    logic [COLS-1:0]  col_gnt;
    logic [ROW_W-1:0] row_addr;
    logic [COL_W-1:0] col_addr;
    logic             row_rel;                  // Row group exhausted
    logic             col_rel;                  // Column group exhausted

    logic             row_en;                   // Step the row arbiter
    logic             col_en;                   // Step the column arbiter
    logic             refresh;                  // Clear both arbiters

    // ------------------------------
    // Request reduction
    // ------------------------------
    always_comb
    begin
        for (int r = 0; r < ROWS; r++)
        begin
            row_req[r] = |req_i[r];             // Row wants service if any pixel does
        end
    end

    // Column requests follow the held row grant
    assign col_req = req_i[row_addr];

    // ------------------------------
    // Row and column arbiters
    // ------------------------------
    rr_group_arbiter #(
        .N (ROWS)
    ) u_row_arb (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (row_en),
        .refresh_i     (refresh),
        .req_i         (row_req),
        .gnt_o         (row_gnt),
        .addr_o        (row_addr),
        .grp_release_o (row_rel)
    );

    rr_group_arbiter #(
        .N (COLS)
    ) u_col_arb (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (col_en),
        .refresh_i     (refresh),
        .req_i         (col_req),
        .gnt_o         (col_gnt),
        .addr_o        (col_addr),
        .grp_release_o (col_rel)
    );

    // ------------------------------
    // Control FSM
    // ------------------------------
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            state_q <= ARB_IDLE;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d = state_q;
        row_en  = 1'b0;
        col_en  = 1'b0;
        refresh = 1'b0;
        case (state_q)
            ARB_IDLE:
            begin
                if (enable_i)
                begin
                    row_en  = 1'b1;             // First row pick on the way in
                    state_d = ARB_ROW_GRANT;
                end
            end
            ARB_ROW_GRANT:
            begin
                if (!enable_i)
                begin
                    refresh = 1'b1;             // Abort, forget the sweep
                    state_d = ARB_IDLE;
                end
                else if (|row_gnt)
                begin
                    col_en  = 1'b1;             // Start the column sweep of this row
                    state_d = ARB_COL_GRANT;
                end
                else
                    row_en  = 1'b1;             // Nothing yet, poll rows again
            end
            ARB_COL_GRANT:
            begin
                if (!enable_i)
                begin
                    refresh = 1'b1;
                    state_d = ARB_IDLE;
                end
                else
                begin
                    col_en = 1'b1;              // One pixel per cycle
                    // Column grant drops to zero on this step, move to the next row
                    if (col_rel)
                    begin
                        row_en  = 1'b1;
                        state_d = ARB_ROW_GRANT;
                    end
                end
            end
            default:
                state_d = ARB_IDLE;
        endcase
    end

    // ------------------------------
    // Grant matrix and status
    // ------------------------------
    always_comb
    begin
        gnt_o = '0;
        if (|row_gnt && |col_gnt)               // Both levels must hold a grant
            gnt_o[row_addr][col_addr] = 1'b1;
    end

    assign addr_o.x = row_addr;
    assign addr_o.y = col_addr;

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            active_o      <= 1'b0;
            grp_release_o <= 1'b0;
        end
        else
        begin
            active_o      <= |col_gnt;
            // Last column of the last row ends the whole group
            grp_release_o <= enable_i & row_rel & col_rel;
        end
    end

endmodule

/* hdl/pixel_array_top.sv */
// Top level joining the pixel arbiter and the event encoder
`timescale 1ns/1ps

module pixel_array_top import aer_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        enable_i,               // Arbitration enable level
    input  pixel_mat_t  req_i,                  // Pixel request levels
    output pixel_mat_t  gnt_o,                  // Pixel grants, one-hot or zero
    output pixel_addr_t addr_o,                 // Current grant address
    output aer_event_t  event_o,                // Address event
    output logic        event_valid_o,          // Event strobe
    output logic        active_o,               // Column sweep in progress
    output logic        any_req_o,              // Some pixel is requesting
    output logic        grp_release_o           // End of full sweep
);

    pixel_mat_t  gnt;                           // Grant shared with the encoder
    pixel_addr_t addr;

    // ------------------------------
    // Arbitration
    // ------------------------------
    pixel_arbiter u_arbiter (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (enable_i),
        .req_i         (req_i),
        .gnt_o         (gnt),
        .addr_o        (addr),
        .active_o      (active_o),
        .grp_release_o (grp_release_o)
    );

    // Event generation
    aer_event_encoder u_encoder (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .gnt_i         (gnt),
        .addr_i        (addr),
        .event_o       (event_o),
        .event_valid_o (event_valid_o)
    );

    assign gnt_o     = gnt;
    assign addr_o    = addr;
    assign any_req_o = |req_i;                  // Plain OR, no reset gating

endmodule

/* hdl/rr_group_arbiter.sv */
// Round-robin group arbiter with served mask, one-hot grant and group release
`timescale 1ns/1ps

module rr_group_arbiter #(
    parameter int N = 4                         // Number of requesters
)
(
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   enable_i,    // Advance to the next requester
    input  logic                   refresh_i,   // Drop grant and forget the group
    input  logic [N-1:0]           req_i,
    output logic [N-1:0]           gnt_o,       // One-hot or zero
    output logic [$clog2(N)-1:0]   addr_o,      // Index of the granted requester
    output logic                   grp_release_o // Group exhausted on this enable
);

    logic [N-1:0]         served_q;             // Requesters already served this group
    logic [N-1:0]         gnt_q;                // Registered grant
    logic [$clog2(N)-1:0] addr_q;               // Registered grant index

    logic [N-1:0]         served_nxt;           // Mask including the current grant
    logic [N-1:0]         cand;                 // Pending and not yet served
    logic                 found;                // Any candidate left
    logic [N-1:0]         gnt_nxt;
    logic [$clog2(N)-1:0] addr_nxt;

    // ------------------------------
    // Candidate search
    // ------------------------------
    always_comb
    begin
        served_nxt = served_q | gnt_q;          // Current holder counts as served
        cand       = req_i & ~served_nxt;
        found      = |cand;
        gnt_nxt    = '0;
        addr_nxt   = '0;
        // Walk down so the lowest index wins
        for (int i = N - 1; i >= 0; i--)
        begin
            if (cand[i])
            begin
                gnt_nxt    = '0;
                gnt_nxt[i] = 1'b1;
                addr_nxt   = i[$clog2(N)-1:0];
            end
        end
    end

    // Release fires only on an enabled step that finds nobody left
    assign grp_release_o = enable_i & ~refresh_i & ~found;

    // ------------------------------
    // Grant and mask registers
    // ------------------------------
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            served_q <= '0;
            gnt_q    <= '0;
            addr_q   <= '0;
        end
        else if (refresh_i)                     // Abort wins over enable
        begin
            served_q <= '0;
            gnt_q    <= '0;
            addr_q   <= '0;
        end
        else if (enable_i)
        begin
            if (found)
            begin
                served_q <= served_nxt;         // Remember who had the grant
                gnt_q    <= gnt_nxt;
                addr_q   <= addr_nxt;
            end
            else
            begin
                served_q <= '0;                 // Group done, start a fresh one
                gnt_q    <= '0;
                addr_q   <= '0;
            end
        end
        // Otherwise hold the grant
    end

    assign gnt_o  = gnt_q;
    assign addr_o = addr_q;

endmodule

/* test/pixel_arbiter_assertions.sv */
// Bound checks on the arbiter grants, FSM state and group release pulse
`timescale 1ns/1ps

module pixel_arbiter_assertions import aer_pkg::*;
(
    input logic            clk_i,
    input logic            reset_i,
    input arb_state_t      state_i,             // Arbiter FSM state
    input pixel_mat_t      gnt_i,               // Grant matrix
    input logic [ROWS-1:0] row_gnt_i,           // Registered row arbiter grant
    input logic [COLS-1:0] col_gnt_i,           // Registered column arbiter grant
    input logic            grp_release_i        // Registered group release
);

    int fail_count = 0;                         // Failed assertions so far

    // ------------------------------
    // Grant matrix
    // ------------------------------
    // Each level holds at most one requester, so the pixel grant is one-hot or zero
    gnt_onehot_a: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(row_gnt_i) && $onehot0(col_gnt_i))
    else
    begin
        $error("Row or column grant holds more than one requester");
        fail_count++;
    end

    // Pixels are only granted while the column sweep runs
    gnt_state_a: assert property (@(posedge clk_i) disable iff (reset_i)
        (state_i != ARB_COL_GRANT) |-> (gnt_i == '0))
    else
    begin
        $error("Pixel grant outside the column grant state");
        fail_count++;
    end

    // Group release is a single-cycle pulse
    release_pulse_a: assert property (@(posedge clk_i) disable iff (reset_i)
        grp_release_i |=> !grp_release_i)
    else
    begin
        $error("Group release held for more than one cycle");
        fail_count++;
    end

endmodule

bind pixel_arbiter pixel_arbiter_assertions u_assertions (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .state_i       (state_q),
    .gnt_i         (gnt_o),
    .row_gnt_i     (row_gnt),
    .col_gnt_i     (col_gnt),
    .grp_release_i (grp_release_o)
);

/* test/tb_pixel_array.sv */
// Testbench for the pixel array arbiter with pixel model, event monitor, tests and watchdog
`timescale 1ns/1ps

module tb_pixel_array import aer_pkg::*; ();

    localparam int CLK_PERIOD = 100;            // ns
    localparam int RESET_CYC  = 16;
    // Per-test cycle budgets, reset first and random patterns last
    localparam int BUDGET_CYC = RESET_CYC + 30 + 40 + 60 + 80 + 100 + 20 * 40;

    logic        clk_i    = 1'b0;
    logic        reset_i  = 1'b1;
    logic        enable_i = 1'b0;
    pixel_mat_t  req_i    = '0;                 // Owned by the pixel model
    pixel_mat_t  gnt_o;
    pixel_addr_t addr_o;
    aer_event_t  event_o;
    logic        event_valid_o;
    logic        active_o;
    logic        any_req_o;
    logic        grp_release_o;

    pixel_mat_t  raise_mask = '0;               // Requests to raise on the next drive
    pixel_mat_t  drop_mask  = '0;               // Requests to withdraw on the next drive
    logic        enable_set = 1'b0;             // Enable level for the next drive
    aer_event_t  events[$];                     // Collected address events
    int          rel_count  = 0;                // Group release pulses seen
    int          rel_events = 0;                // Queue size at the last release
    int          seed       = 32'h0d76_3801;

    pixel_array_top uut (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .enable_i      (enable_i),
        .req_i         (req_i),
        .gnt_o         (gnt_o),
        .addr_o        (addr_o),
        .event_o       (event_o),
        .event_valid_o (event_valid_o),
        .active_o      (active_o),
        .any_req_o     (any_req_o),
        .grp_release_o (grp_release_o)
    );

    initial
    begin
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ------------------------------
    // Pixel model and monitor
    // ------------------------------
    always @(posedge clk_i)
    begin
        #5;
        req_i      = (req_i & ~gnt_o & ~drop_mask) | raise_mask; // Granted pixels let go
        raise_mask = '0;
        drop_mask  = '0;
        enable_i   = enable_set;
    end

    always @(negedge clk_i)
    begin
        if (event_valid_o)
            events.push_back(event_o);
        if (grp_release_o)
        begin
            rel_count++;
            rel_events = events.size();         // Events already out when the sweep ended
        end
    end

    initial
    begin
        #(BUDGET_CYC * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d clock cycles", BUDGET_CYC);
        $display("Some tests failed");
        $fatal(1, "Watchdog expired");
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected)
        begin
            $display("FAIL @%0t ns: %s, got %0h expected %0h", $time, what, actual, expected);
            $display("Some tests failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #25;                                    // Well after the input drive point
    endtask

    task automatic post_requests(input pixel_mat_t set, input pixel_mat_t clr);
        raise_mask = raise_mask | set;
        drop_mask  = drop_mask | clr;
    endtask

    task automatic wait_events(input int count, input int limit);
        int n;
        n = 0;
        while (events.size() < count && n < limit)
        begin
            next_cycle();
            n++;
        end
        compare(events.size(), count, "event count");
    endtask

    task automatic wait_grant(input int r, input int c, input int limit);
        int n;
        n = 0;
        while (!gnt_o[r][c] && n < limit)
        begin
            next_cycle();
            n++;
        end
        compare(gnt_o[r][c], 1'b1, "grant of the expected pixel");
    endtask

    // Events from index first must visit the set pixels row by row, columns ascending
    task automatic expect_row_major(input int first, input pixel_mat_t pattern);
        int idx;
        idx = first;
        for (int r = 0; r < ROWS; r++)
        begin
            for (int c = 0; c < COLS; c++)
            begin
                if (pattern[r][c])
                begin
                    compare(events[idx].addr, {r[ROW_W-1:0], c[COL_W-1:0]}, "event address");
                    idx++;
                end
            end
        end
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic reset_state();
        pixel_mat_t pattern;
        pattern = 16'hA5C3;
        post_requests(pattern, '0);
        next_cycle();
        repeat (20)
        begin
            compare(gnt_o, '0, "grant while disabled");
            compare(event_valid_o, 1'b0, "event strobe while disabled");
            compare(active_o, 1'b0, "active while disabled");
            compare(grp_release_o, 1'b0, "group release while disabled");
            compare(any_req_o, 1'b1, "any request");
            next_cycle();
        end
        compare(req_i, pattern, "requests held while disabled");
        post_requests('0, '1);                  // Withdraw everything
        next_cycle();
        compare(any_req_o, 1'b0, "any request with none pending");
    endtask

    task automatic single_pixel();
        pixel_mat_t pix;
        pix       = '0;
        pix[1][2] = 1'b1;
        events.delete();
        enable_set = 1'b1;
        post_requests(pix, '0);
        wait_grant(1, 2, 20);
        compare(gnt_o, pix, "one-hot grant position");
        compare(addr_o, {2'd1, 2'd2}, "grant address");
        compare(active_o, 1'b0, "active before the column grant");
        next_cycle();
        compare(active_o, 1'b1, "active after the column grant");
        wait_events(1, 10);
        repeat (5) next_cycle();
        compare(events.size(), 1, "single pixel event count");
        expect_row_major(0, pix);
    endtask

    task automatic full_sweep();
        int rel_before;
        events.delete();
        rel_before = rel_count;
        post_requests('1, '0);
        wait_events(16, 60);
        repeat (4) next_cycle();
        compare(events.size(), 16, "full sweep event count");
        expect_row_major(0, '1);
        for (int i = 1; i < 16; i++)
            compare(events[i].ts > events[i-1].ts, 1'b1, "timestamp order");
        compare(rel_count - rel_before, 1, "group release pulses");
        compare(rel_events, 16, "events out before group release");
    endtask

    task automatic fairness();
        pixel_mat_t first;
        first       = '0;
        first[0][0] = 1'b1;
        events.delete();
        post_requests('1, '0);
        wait_grant(0, 0, 10);
        post_requests(first, '0);               // Same pixel asks again at once
        wait_events(17, 80);
        repeat (4) next_cycle();
        compare(events.size(), 17, "fairness event count");
        expect_row_major(0, '1);                // Whole group before the repeat
        compare(events[16].addr, '0, "repeat pixel served after the group");
    endtask

    task automatic abort_resume();
        pixel_mat_t extra;
        pixel_mat_t pending;
        int         n;
        extra       = '0;
        extra[0][0] = 1'b1;
        extra[0][3] = 1'b1;
        events.delete();
        post_requests('1, '0);
        wait_events(6, 40);
        enable_set = 1'b0;                      // Abort inside row 1
        repeat (3) next_cycle();
        n = events.size();
        repeat (10)
        begin
            compare(gnt_o, '0, "grant after abort");
            compare(event_valid_o, 1'b0, "event strobe after abort");
            next_cycle();
        end
        compare(events.size(), n, "events after abort");
        compare($countones(~req_i), n, "pixels served before abort");
        expect_row_major(0, ~req_i);
        pending = req_i | extra;
        post_requests(extra, '0);
        next_cycle();
        enable_set = 1'b1;
        wait_events(n + $countones(pending), 60);
        repeat (4) next_cycle();
        compare(events.size(), n + $countones(pending), "events after resume");
        expect_row_major(n, pending);           // Restart from the lowest pending row
    endtask

    task automatic random_patterns();
        logic [31:0] rnd;
        pixel_mat_t  pattern;
        int          cnt;
        for (int k = 0; k < 20; k++)
        begin
            rnd     = $random(seed);
            pattern = rnd[15:0];
            cnt     = $countones(pattern);
            events.delete();
            post_requests(pattern, '0);
            wait_events(cnt, 40);
            repeat (4) next_cycle();
            compare(events.size(), cnt, "random pattern event count");
            expect_row_major(0, pattern);
        end
    endtask

    // ------------------------------
    // Sequence
    // ------------------------------
    initial
    begin
        repeat (RESET_CYC) @(posedge clk_i);
        #5;
        reset_i = 1'b0;
        next_cycle();
        reset_state();
        single_pixel();
        full_sweep();
        fairness();
        abort_resume();
        random_patterns();
        if (uut.u_arbiter.u_assertions.fail_count == 0)
        begin
            $display("All tests passed");
            $finish;
        end
        else
        begin
            $display("Some tests failed");
            $fatal(1, "Assertion failures were reported");
        end
    end

endmodule
